// ==== common/video_ctrl_pkg.sv ====
// Shared widths, host commands, window FSM states and video structs; import with video_ctrl_pkg::*
package video_ctrl_pkg;

	////////////////////////////////
	// Widths
	////////////////////////////////
	localparam int COORD_W = 12;
	localparam int AR_W    = 13;
	localparam int IO_W    = 16;
	// Sync run-length and line counters
	localparam int RUN_W   = 24;

	////////////////////////////////
	// Host commands and FSM states
	////////////////////////////////
	typedef enum logic [7:0] {
		CMD_NONE         = 8'h00,
		CMD_CONFIG       = 8'h01,
		CMD_VIDEO_TIMING = 8'h20,
		CMD_VSET         = 8'h27,
		CMD_HSET         = 8'h37,
		CMD_AR_CUSTOM    = 8'h3A,
		CMD_STATUS       = 8'h40
	} io_cmd_e;

	typedef enum logic [2:0] {
		WS_SELECT,
		WS_MUL_W_START,
		WS_MUL_W_WAIT,
		WS_MUL_H_START,
		WS_MUL_H_WAIT,
		WS_CLAMP,
		WS_CENTER
	} win_state_e;

	////////////////////////////////
	// Register and result structs
	////////////////////////////////
	typedef struct packed {
		logic [COORD_W-1:0] width;
		logic [COORD_W-1:0] hfp;
		logic [COORD_W-1:0] hs_len;
		logic [COORD_W-1:0] hbp;
		logic [COORD_W-1:0] height;
		logic [COORD_W-1:0] vfp;
		logic [COORD_W-1:0] vs_len;
		logic [COORD_W-1:0] vbp;
		logic               hs_neg;
		logic               vs_neg;
	} video_timing_t;

	// Bit 12 of each custom aspect field means literal size
	typedef struct packed {
		logic [COORD_W-1:0] vset;
		logic [COORD_W-1:0] hset;
		logic               freescale;
		logic [AR_W-1:0]    arc1x;
		logic [AR_W-1:0]    arc1y;
		logic [AR_W-1:0]    arc2x;
		logic [AR_W-1:0]    arc2y;
	} scale_cfg_t;

	typedef struct packed {
		logic [COORD_W-1:0] hmin;
		logic [COORD_W-1:0] hmax;
		logic [COORD_W-1:0] vmin;
		logic [COORD_W-1:0] vmax;
	} win_bounds_t;

	typedef struct packed {
		logic [COORD_W-1:0] arx;
		logic [COORD_W-1:0] ary;
		logic               arxy;
	} ar_result_t;

	// 1080p60 CEA timing with positive syncs
	localparam video_timing_t DEFAULT_TIMING = '{
		width:  12'd1920, hfp: 12'd88, hs_len: 12'd44, hbp: 12'd148,
		height: 12'd1080, vfp: 12'd4,  vs_len: 12'd5,  vbp: 12'd36,
		hs_neg: 1'b0,     vs_neg: 1'b0
	};

endpackage

// ==== hw/window_calc/umuldiv.sv ====
// Iterative unsigned mul1*mul2/div; pulse i_start, read o_result once o_busy drops
`timescale 1ns/10ps

module umuldiv import video_ctrl_pkg::*; #(
	parameter int W = COORD_W
) (
	input  logic         clk_sys,
	input  logic         resetd,
	input  logic         i_start,
	input  logic [W-1:0] i_mul1,
	input  logic [W-1:0] i_mul2,
	input  logic [W-1:0] i_div,
	output logic         o_busy,
	output logic [W-1:0] o_result
);

	localparam int CNT_W = $clog2(2*W+1);

	logic [CNT_W-1:0] cnt;
	logic [2*W-1:0]   quo;
	logic [W-1:0]     rem;
	logic [W-1:0]     div_r;
	logic [W:0]       rem_sh;
	logic [W:0]       diff;

	// Next partial remainder and trial subtraction
	assign rem_sh = {rem, quo[2*W-1]};
	assign diff   = rem_sh - {1'b0, div_r};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			cnt    <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			cnt    <= CNT_W'(2*W);
		end else if (o_busy) begin
			cnt <= cnt - 1'b1;
			if (cnt == CNT_W'(1))
				o_busy <= 1'b0;
		end
	end

	// Product latched as dividend and divided one quotient bit per cycle
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo   <= i_mul1 * i_mul2;
			rem   <= '0;
			div_r <= i_div;
		end else if (o_busy) begin
			if (!diff[W]) begin
				rem <= diff[W-1:0];
				quo <= {quo[2*W-2:0], 1'b1};
			end else begin
				rem <= rem_sh[W-1:0];
				quo <= {quo[2*W-2:0], 1'b0};
			end
		end
	end

	assign o_result = quo[W-1:0];

endmodule

// ==== hw/window_calc/ar_window_calc.sv ====
// Aspect selection and looping window FSM; derives the displayed picture rectangle
`timescale 1ns/10ps

module ar_window_calc import video_ctrl_pkg::*; #(
	parameter int W = COORD_W
) (
	input  logic            clk_sys,
	input  logic            resetd,
	input  video_timing_t   i_timing,
	input  scale_cfg_t      i_scale,
	input  logic [AR_W-1:0] i_video_arx,
	input  logic [AR_W-1:0] i_video_ary,
	output ar_result_t      o_ar,
	output win_bounds_t     o_window
);

	win_state_e         state;
	logic [COORD_W-1:0] hdmi_w, hdmi_h;
	logic [COORD_W-1:0] w_calc, h_calc;
	logic [COORD_W-1:0] vid_w, vid_h;
	logic [COORD_W-1:0] h_off, v_off;
	logic               md_start, md_busy;
	logic [W-1:0]       md_mul1, md_mul2, md_div, md_res;

	////////////////////////////////
	// Output size and aspect
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		hdmi_h <= (i_scale.vset != '0 && i_scale.vset < i_timing.height) ?
			i_scale.vset : i_timing.height;
		hdmi_w <= (i_scale.hset != '0 && i_scale.hset < i_timing.width) ?
			i_scale.hset : i_timing.width;

		// Core aspect wins, else ARX picks a custom pair
		if (i_video_ary != '0) begin
			o_ar.arx  <= i_video_arx[COORD_W-1:0];
			o_ar.ary  <= i_video_ary[COORD_W-1:0];
			o_ar.arxy <= i_video_arx[AR_W-1] | i_video_ary[AR_W-1];
		end else if (i_video_arx == AR_W'(1)) begin
			o_ar.arx  <= i_scale.arc1x[COORD_W-1:0];
			o_ar.ary  <= i_scale.arc1y[COORD_W-1:0];
			o_ar.arxy <= i_scale.arc1x[AR_W-1] | i_scale.arc1y[AR_W-1];
		end else if (i_video_arx == AR_W'(2)) begin
			o_ar.arx  <= i_scale.arc2x[COORD_W-1:0];
			o_ar.ary  <= i_scale.arc2y[COORD_W-1:0];
			o_ar.arxy <= i_scale.arc2x[AR_W-1] | i_scale.arc2y[AR_W-1];
		end else begin
			o_ar <= '0;
		end
	end

	assign h_off = (i_timing.width - vid_w) >> 1;
	assign v_off = (i_timing.height - vid_h) >> 1;

	////////////////////////////////
	// Window FSM
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= WS_SELECT;
			md_start <= 1'b0;
			o_window <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				WS_SELECT: begin
					if (i_scale.freescale || o_ar.arx == '0 || o_ar.ary == '0) begin
						w_calc <= hdmi_w;
						h_calc <= hdmi_h;
						state  <= WS_CLAMP;
					end else if (o_ar.arxy) begin
						w_calc <= o_ar.arx;
						h_calc <= o_ar.ary;
						state  <= WS_CLAMP;
					end else begin
						state <= WS_MUL_W_START;
					end
				end
				WS_MUL_W_START: begin
					md_mul1  <= W'(hdmi_h);
					md_mul2  <= W'(o_ar.arx);
					md_div   <= W'(o_ar.ary);
					md_start <= 1'b1;
					state    <= WS_MUL_W_WAIT;
				end
				WS_MUL_W_WAIT: begin
					// Busy shows one cycle after start
					if (!md_start && !md_busy) begin
						w_calc <= md_res[COORD_W-1:0];
						state  <= WS_MUL_H_START;
					end
				end
				WS_MUL_H_START: begin
					md_mul1  <= W'(hdmi_w);
					md_mul2  <= W'(o_ar.ary);
					md_div   <= W'(o_ar.arx);
					md_start <= 1'b1;
					state    <= WS_MUL_H_WAIT;
				end
				WS_MUL_H_WAIT: begin
					if (!md_start && !md_busy) begin
						h_calc <= md_res[COORD_W-1:0];
						state  <= WS_CLAMP;
					end
				end
				WS_CLAMP: begin
					vid_w <= (w_calc > hdmi_w) ? hdmi_w : w_calc;
					vid_h <= (h_calc > hdmi_h) ? hdmi_h : h_calc;
					state <= WS_CENTER;
				end
				WS_CENTER: begin
					o_window.hmin <= h_off;
					o_window.hmax <= h_off + vid_w - 1'b1;
					o_window.vmin <= v_off;
					o_window.vmax <= v_off + vid_h - 1'b1;
					state         <= WS_SELECT;
				end
				default: state <= WS_SELECT;
			endcase
		end
	end

	umuldiv #(.W(W)) umuldiv_i (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

endmodule

// ==== hw/host_io/host_cmd_decoder.sv ====
// Host toggle-strobe command port; decodes commands into config, timing and scale registers
`timescale 1ns/10ps

module host_cmd_decoder import video_ctrl_pkg::*; (
	input  logic            clk_sys,
	input  logic            resetd,
	input  logic            i_io_sel,
	input  logic            i_io_clk,
	input  logic [IO_W-1:0] i_io_din,
	input  ar_result_t      i_ar,
	output logic            o_io_ack,
	output logic [IO_W-1:0] o_io_dout,
	output video_timing_t   o_timing,
	output scale_cfg_t      o_scale,
	output logic            o_csync_en
);

	logic       rack;
	logic       strobe;
	logic       has_cmd;
	io_cmd_e    cmd;
	logic [3:0] cnt;

	// Map a command byte to a known command or CMD_NONE
	function automatic io_cmd_e decode_cmd(input logic [7:0] code);
		io_cmd_e c;
		case (code)
			8'h01:   c = CMD_CONFIG;
			8'h20:   c = CMD_VIDEO_TIMING;
			8'h27:   c = CMD_VSET;
			8'h37:   c = CMD_HSET;
			8'h3A:   c = CMD_AR_CUSTOM;
			8'h40:   c = CMD_STATUS;
			default: c = CMD_NONE;
		endcase
		return c;
	endfunction

	////////////////////////////////
	// Strobe and acknowledge
	////////////////////////////////
	assign strobe = i_io_clk & ~rack;

	// Ack echoes the host clock two cycles later
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			rack     <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	////////////////////////////////
	// Command and register writes
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd    <= 1'b0;
			cmd        <= CMD_NONE;
			cnt        <= '0;
			o_io_dout  <= '0;
			o_timing   <= DEFAULT_TIMING;
			o_scale    <= '0;
			o_csync_en <= 1'b0;
		end else if (!i_io_sel) begin
			has_cmd   <= 1'b0;
			cmd       <= CMD_NONE;
			cnt       <= '0;
			o_io_dout <= '0;
		end else if (strobe) begin
			o_io_dout <= '0;
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= decode_cmd(i_io_din[7:0]);
				cnt     <= '0;
			end else begin
				// Saturate so late words never alias onto word 0
				if (cnt != '1)
					cnt <= cnt + 4'd1;
				case (cmd)
					CMD_CONFIG: o_csync_en <= i_io_din[3];
					CMD_VIDEO_TIMING: begin
						case (cnt)
							4'd0: o_timing.width  <= i_io_din[COORD_W-1:0];
							4'd1: o_timing.hfp    <= i_io_din[COORD_W-1:0];
							4'd2: begin
								o_timing.hs_len <= i_io_din[COORD_W-1:0];
								o_timing.hs_neg <= i_io_din[15];
							end
							4'd3: o_timing.hbp    <= i_io_din[COORD_W-1:0];
							4'd4: o_timing.height <= i_io_din[COORD_W-1:0];
							4'd5: o_timing.vfp    <= i_io_din[COORD_W-1:0];
							4'd6: begin
								o_timing.vs_len <= i_io_din[COORD_W-1:0];
								o_timing.vs_neg <= i_io_din[15];
							end
							4'd7: o_timing.vbp    <= i_io_din[COORD_W-1:0];
							default: ;
						endcase
					end
					CMD_VSET: begin
						if (cnt == 4'd0)
							o_scale.vset <= i_io_din[COORD_W-1:0];
					end
					CMD_HSET: begin
						if (cnt == 4'd0) begin
							o_scale.freescale <= i_io_din[15];
							o_scale.hset      <= i_io_din[COORD_W-1:0];
						end
					end
					CMD_AR_CUSTOM: begin
						case (cnt)
							4'd0: o_scale.arc1x <= i_io_din[AR_W-1:0];
							4'd1: o_scale.arc1y <= i_io_din[AR_W-1:0];
							4'd2: o_scale.arc2x <= i_io_din[AR_W-1:0];
							4'd3: o_scale.arc2y <= i_io_din[AR_W-1:0];
							default: ;
						endcase
					end
					CMD_STATUS: begin
						// Aspect readback with the literal flag on top
						case (cnt)
							4'd0: o_io_dout <= {i_ar.arxy, {(IO_W-COORD_W-1){1'b0}}, i_ar.arx};
							4'd1: o_io_dout <= {i_ar.arxy, {(IO_W-COORD_W-1){1'b0}}, i_ar.ary};
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hw/sync_polarity_fix.sv ====
// Sync polarity normalizer; measures high and low run lengths and flips to active-high
`timescale 1ns/10ps

module sync_polarity_fix import video_ctrl_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic             s1, s2;
	logic [RUN_W-1:0] run_cnt;
	logic [RUN_W-1:0] len_hi, len_lo;
	logic             pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1      <= 1'b0;
			s2      <= 1'b0;
			run_cnt <= '0;
			len_hi  <= '0;
			len_lo  <= '0;
			pol     <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Run length restarts on every edge
			if (s1 != s2)
				run_cnt <= '0;
			else if (run_cnt != '1)
				run_cnt <= run_cnt + 1'b1;

			// Rising edge closes a low phase, falling edge a high one
			if (s1 && !s2)
				len_lo <= run_cnt;
			if (!s1 && s2)
				len_hi <= run_cnt;

			pol <= len_hi > len_lo;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

// ==== hw/csync_gen.sv ====
// Composite sync from active-high hsync and vsync, serrated during vsync, one cycle delay
`timescale 1ns/10ps

module csync_gen import video_ctrl_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	output logic o_csync
);

	logic             prev_hs;
	logic             hs_rise, hs_fall;
	logic [RUN_W-1:0] cnt;
	logic [RUN_W-1:0] line_len;
	logic [RUN_W-1:0] hs_len;

	assign hs_rise = i_hsync & ~prev_hs;
	assign hs_fall = ~i_hsync & prev_hs;

	////////////////////////////////
	// Line and hsync measurement
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			cnt      <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			prev_hs <= i_hsync;
			// cnt holds cycles since the last hsync rise
			if (hs_rise)
				cnt <= RUN_W'(1);
			else if (cnt != '1)
				cnt <= cnt + 1'b1;
			if (hs_rise)
				line_len <= cnt;
			if (hs_fall)
				hs_len <= cnt;
		end
	end

	////////////////////////////////
	// Output
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_csync <= 1'b0;
		end else if (!i_vsync) begin
			o_csync <= i_hsync;
		end else if (hs_rise) begin
			o_csync <= 1'b1;
		end else if (cnt == line_len - hs_len) begin
			// Low for the last hsync length of the line
			o_csync <= 1'b0;
		end
	end

endmodule

// ==== hw/video_ctrl_top.sv ====
// Host control and video geometry top; joins host decoder, window calculator and sync path
`timescale 1ns/10ps

module video_ctrl_top import video_ctrl_pkg::*; #(
	parameter int W = COORD_W
) (
	input  logic            clk_sys,
	input  logic            resetd,
	input  logic            i_io_sel,
	input  logic            i_io_clk,
	input  logic [IO_W-1:0] i_io_din,
	input  logic [AR_W-1:0] i_video_arx,
	input  logic [AR_W-1:0] i_video_ary,
	input  logic            i_hs,
	input  logic            i_vs,
	output logic            o_io_ack,
	output logic [IO_W-1:0] o_io_dout,
	output win_bounds_t     o_window,
	output logic            o_hsync,
	output logic            o_vsync
);

	video_timing_t timing;
	scale_cfg_t    scale;
	ar_result_t    ar;
	logic          csync_en;
	logic          hs_fix, vs_fix;
	logic          csync;

	host_cmd_decoder host_cmd_decoder_i (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_sel   (i_io_sel),
		.i_io_clk   (i_io_clk),
		.i_io_din   (i_io_din),
		.i_ar       (ar),
		.o_io_ack   (o_io_ack),
		.o_io_dout  (o_io_dout),
		.o_timing   (timing),
		.o_scale    (scale),
		.o_csync_en (csync_en)
	);

	ar_window_calc #(.W(W)) ar_window_calc_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_timing    (timing),
		.i_scale     (scale),
		.i_video_arx (i_video_arx),
		.i_video_ary (i_video_ary),
		.o_ar        (ar),
		.o_window    (o_window)
	);

	////////////////////////////////
	// Sync path
	////////////////////////////////
	sync_polarity_fix sync_fix_h_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (hs_fix)
	);

	sync_polarity_fix sync_fix_v_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (vs_fix)
	);

	csync_gen csync_gen_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hsync (hs_fix),
		.i_vsync (vs_fix),
		.o_csync (csync)
	);

	// Config bit 3 puts composite sync on the hsync pin
	assign o_hsync = csync_en ? csync : hs_fix;
	assign o_vsync = vs_fix;

endmodule

// ==== verif/tb_video_ctrl.sv ====
// Testbench for video_ctrl_top; replays verif/video_ctrl_tests.txt through the host port and sync inputs
`timescale 1ns/10ps

module tb_video_ctrl import video_ctrl_pkg::*; ();

	localparam int          REC       = 21;
	localparam int          MAX_TESTS = 32;
	localparam int          ACK_LIMIT = 100;
	localparam int          SETTLE    = 200;
	localparam logic [31:0] SEED      = 32'h97cf925e;

	// Field offsets inside one test record
	localparam int F_KIND = 0;
	localparam int F_CMD  = 1;
	localparam int F_NW   = 2;
	localparam int F_WORD = 3;
	localparam int F_ARX  = 11;
	localparam int F_ARY  = 12;
	localparam int F_SYNC = 13;
	localparam int F_EXP  = 17;

	logic            clk_sys;
	logic            resetd;
	logic            i_io_sel;
	logic            i_io_clk;
	logic [IO_W-1:0] i_io_din;
	logic [AR_W-1:0] i_video_arx;
	logic [AR_W-1:0] i_video_ary;
	logic            i_hs;
	logic            i_vs;
	logic            o_io_ack;
	logic [IO_W-1:0] o_io_dout;
	win_bounds_t     o_window;
	logic            o_hsync;
	logic            o_vsync;

	logic [15:0]     vec [0:REC*MAX_TESTS-1];
	logic [IO_W-1:0] rd_words [0:7];
	int              errors;
	logic            timed_out;

	always #2 clk_sys = ~clk_sys;

	video_ctrl_top video_ctrl_top_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_clk    (i_io_clk),
		.i_io_din    (i_io_din),
		.i_video_arx (i_video_arx),
		.i_video_ary (i_video_ary),
		.i_hs        (i_hs),
		.i_vs        (i_vs),
		.o_io_ack    (o_io_ack),
		.o_io_dout   (o_io_dout),
		.o_window    (o_window),
		.o_hsync     (o_hsync),
		.o_vsync     (o_vsync)
	);

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			errors++;
		end
	endtask

	////////////////////////////////
	// Host port
	////////////////////////////////
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (o_io_ack !== level && n < ACK_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (o_io_ack !== level) begin
			$display("Timeout: host acknowledge did not reach %0d within %0d cycles",
				level, ACK_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	// One word is a rising strobe; the falling half just returns the handshake
	task automatic send_word(input logic [IO_W-1:0] word);
		int gap;
		gap = $urandom % 4;
		repeat (gap) @(negedge clk_sys);
		i_io_din = word;
		i_io_clk = 1'b1;
		@(negedge clk_sys);
		wait_ack(1'b1);
		if (!timed_out) begin
			i_io_clk = 1'b0;
			@(negedge clk_sys);
			wait_ack(1'b0);
		end
	endtask

	task automatic host_command(input logic [7:0] cmd, input int nw, input int b);
		int k;
		i_io_sel = 1'b1;
		@(negedge clk_sys);
		send_word({8'h00, cmd});
		for (k = 0; k < nw && !timed_out; k++) begin
			send_word(vec[b + F_WORD + k]);
			rd_words[k] = o_io_dout;
		end
		i_io_sel = 1'b0;
		@(negedge clk_sys);
	endtask

	////////////////////////////////
	// Sync stimulus and checks
	////////////////////////////////
	// Outputs are sampled at the next falling edge before the next step is driven
	task automatic run_sync(input int b, input bit csync_mode);
		int   hhi, hlo, vhi, vlo;
		int   line, frame, t, ph_h, ph_v, lows;
		logic hs_now, vs_now;
		logic hs_prev, vs_prev;
		hhi     = vec[b + F_SYNC];
		hlo     = vec[b + F_SYNC + 1];
		vhi     = vec[b + F_SYNC + 2];
		vlo     = vec[b + F_SYNC + 3];
		line    = hhi + hlo;
		frame   = vhi + vlo;
		lows    = 0;
		hs_prev = 1'b0;
		vs_prev = 1'b0;
		for (t = 0; t < 4 * frame; t++) begin
			ph_h   = t % line;
			ph_v   = t % frame;
			hs_now = (ph_h < hhi);
			vs_now = (ph_v < vhi);
			i_hs   = hs_now;
			i_vs   = vs_now;
			// Registered composite output still shows the previous hsync mid-cycle
			if (csync_mode && t >= 2 * frame && vs_prev) begin
				#1;
				compare("o_hsync one cycle delay", o_hsync, !hs_prev);
			end
			@(negedge clk_sys);
			// First two frames let the polarity and line measurements settle
			if (t >= 2 * frame) begin
				compare("o_vsync", o_vsync, !vs_now);
				if (!csync_mode) begin
					compare("o_hsync", o_hsync, !hs_now);
				end else if (vs_now) begin
					compare("o_hsync outside vsync", o_hsync, !hs_now);
				end else if (ph_v - vhi >= line) begin
					if (!o_hsync)
						lows++;
					if (ph_h == line - 1) begin
						compare("csync low cycles in a vsync line", lows, hlo);
						lows = 0;
					end
				end
			end
			hs_prev = hs_now;
			vs_prev = vs_now;
		end
	endtask

	function automatic string kind_name(input int kind);
		case (kind)
			1:       return "window";
			2:       return "status";
			3:       return "sync polarity";
			4:       return "composite sync";
			default: return "unknown";
		endcase
	endfunction

	////////////////////////////////
	// Main sequence
	////////////////////////////////
	initial begin
		int seed_init;
		int t;
		int base;
		int kind;
		int nw;
		int test_errors;
		int tests_run;
		int tests_failed;
		bit done;
		clk_sys     = 1'b0;
		resetd      = 1'b1;
		i_io_sel    = 1'b0;
		i_io_clk    = 1'b0;
		i_io_din    = '0;
		i_video_arx = '0;
		i_video_ary = '0;
		i_hs        = 1'b0;
		i_vs        = 1'b0;
		errors       = 0;
		timed_out    = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		done         = 1'b0;
		seed_init = $urandom(SEED);
		$readmemh("verif/video_ctrl_tests.txt", vec);

		repeat (10) @(negedge clk_sys);
		resetd = 1'b0;
		@(negedge clk_sys);
		compare("o_io_ack after reset", o_io_ack, 0);

		for (t = 0; t < MAX_TESTS && !done && !timed_out; t++) begin
			base = t * REC;
			kind = vec[base + F_KIND];
			if (kind == 0) begin
				done = 1'b1;
			end else begin
				test_errors = errors;
				i_video_arx = vec[base + F_ARX][AR_W-1:0];
				i_video_ary = vec[base + F_ARY][AR_W-1:0];
				repeat (4) @(negedge clk_sys);
				nw = vec[base + F_NW];
				if (nw > 0)
					host_command(vec[base + F_CMD][7:0], nw, base);
				if (!timed_out) begin
					case (kind)
						1: begin
							// Longer than two full window passes
							repeat (SETTLE) @(negedge clk_sys);
							compare("hmin", o_window.hmin, vec[base + F_EXP]);
							compare("hmax", o_window.hmax, vec[base + F_EXP + 1]);
							compare("vmin", o_window.vmin, vec[base + F_EXP + 2]);
							compare("vmax", o_window.vmax, vec[base + F_EXP + 3]);
						end
						2: begin
							compare("status word 0", rd_words[0], vec[base + F_EXP]);
							compare("status word 1", rd_words[1], vec[base + F_EXP + 1]);
							compare("o_io_dout after deselect", o_io_dout, 0);
						end
						3: run_sync(base, 1'b0);
						4: run_sync(base, 1'b1);
						default: begin
							$display("Test %0d has an unknown kind %0d", t, kind);
							errors++;
						end
					endcase
				end
				tests_run++;
				if (errors != test_errors || timed_out)
					tests_failed++;
				$display("Test %0d (%s): %s", t, kind_name(kind),
					(errors != test_errors || timed_out) ? "FAIL" : "PASS");
			end
		end

		$display("Summary: %0d tests run, %0d failed, %0d check errors",
			tests_run, tests_failed, errors);
		if (timed_out || errors != 0 || tests_failed != 0)
			$display("Test failures found");
		else
			$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verif/video_ctrl_tests.txt ====
// Columns (hex): kind cmd nwords w0..w7  arx ary  hs_hi hs_lo vs_hi vs_lo  e0 e1 e2 e3
// Kind 1 window e0..e3 = hmin hmax vmin vmax, 2 status words, 3 sync polarity, 4 composite sync
// Reset defaults with no aspect give the full 1920x1080 screen
1 0  0 0 0 0 0 0 0 0 0  0 0  0 0 0 0  0 77F 0 437
// 1280x720 timing with core 4:3 pillarbox
1 20 8 500 6E 28 DC 2D0 5 5 14  4 3  0 0 0 0  A0 45F 0 2CF
// Same timing with core 3:4
1 0  0 0 0 0 0 0 0 0 0  3 4  0 0 0 0  172 38D 0 2CF
// 1024x768 timing with core 16:9 letterbox
1 20 8 400 18 88 A0 300 3 6 1D  10 9  0 0 0 0  0 3FF 60 29F
// Height limited to 600
1 27 1 258 0 0 0 0 0 0 0  4 3  0 0 0 0  70 38F 54 2AB
// Width limited to 640
1 37 1 280 0 0 0 0 0 0 0  4 3  0 0 0 0  C0 33F 90 26F
// Free scale fills 640x600 whatever the aspect
1 37 1 8280 0 0 0 0 0 0 0  10 9  0 0 0 0  C0 33F 54 2AB
// Width limit cleared, height still 600
1 37 1 0 0 0 0 0 0 0 0  4 3  0 0 0 0  70 38F 54 2AB
// Height limit cleared, no aspect
1 27 1 0 0 0 0 0 0 0 0  0 0  0 0 0 0  0 3FF 0 2FF
// Custom pairs 5:4 and literal 800x600, ARX=1 picks 5:4
1 3A 4 5 4 1320 1258 0 0 0 0  1 0  0 0 0 0  20 3DF 0 2FF
// ARX=2 picks the literal size
1 0  0 0 0 0 0 0 0 0 0  2 0  0 0 0 0  70 38F 54 2AB
// Status readback of the literal pair
2 40 2 0 0 0 0 0 0 0 0  2 0  0 0 0 0  8320 8258 0 0
// Status readback of the 5:4 pair
2 40 2 0 0 0 0 0 0 0 0  1 0  0 0 0 0  5 4 0 0
// Negative syncs, 48-cycle lines and 13-line frames
3 0  0 0 0 0 0 0 0 0 0  0 0  28 8 1E0 90  0 0 0 0
// Composite sync on o_hsync after config bit 3
4 1  1 8 0 0 0 0 0 0 0  0 0  28 8 1E0 90  0 0 0 0
// End of tests
0

// ==== tb.f ====
common/video_ctrl_pkg.sv
hw/window_calc/umuldiv.sv
hw/window_calc/ar_window_calc.sv
hw/host_io/host_cmd_decoder.sv
hw/sync_polarity_fix.sv
hw/csync_gen.sv
hw/video_ctrl_top.sv
verif/tb_video_ctrl.sv

// ==== Bender.yml ====
package:
  name: video_ctrl

sources:
  - common/video_ctrl_pkg.sv
  - hw/window_calc/umuldiv.sv
  - hw/window_calc/ar_window_calc.sv
  - hw/host_io/host_cmd_decoder.sv
  - hw/sync_polarity_fix.sv
  - hw/csync_gen.sv
  - hw/video_ctrl_top.sv
  - target: simulation
    files:
      - verif/tb_video_ctrl.sv
